// File: include/snd_settings.svh
/* sound board build settings */
`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

// pcm rom address, bank bits on top of a 16-bit pointer
`define SND_ROM_AW 18

// sample enable rate is clk * N / M
`define SND_CEN_N 1
`define SND_CEN_M 4

// mixer gains, 8 means unity once the sum is shifted
`define SND_GAIN_FM 8
`define SND_MIX_SHIFT 3

// effects gain per fxlevel setting
`define SND_FX_GAIN0 8'h08
`define SND_FX_GAIN1 8'h0C
`define SND_FX_GAIN2 8'h10
`define SND_FX_GAIN3 8'h14

// pcm rom levels are offset binary around this point
`define SND_PCM_BIAS 64

`endif

// File: logic/pcm_channel.sv
/* pcm sample playback voice */
`include "snd_settings.svh"

module pcm_channel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  snd_bus_pkg::bus_req_t      bus,
    input  logic                       sel,
    input  logic [1:0]                 bank,
    output logic [`SND_ROM_AW-1:0]     rom_addr,
    input  logic [7:0]                 rom_data,
    output logic                       rom_cs,
    input  logic                       rom_ok,
    output logic                       busy,
    output snd_audio_pkg::pcm_sample_t voice
);
    import snd_audio_pkg::*;

    typedef enum logic {ST_HOLD, ST_FETCH} fetch_st_e;

    fetch_st_e          st;
    logic [15:0]        start;
    logic [15:0]        ptr;       // next byte to fetch
    logic [3:0]         vol;
    logic               buf_full;
    logic               stale;     // rom reply belongs to an older trigger
    logic               wr_reg;
    logic               trig;
    logic               fetch_go;
    logic               take;
    pcm_rom_byte_u      rom_byte;
    pcm_rom_byte_u      buf_byte;
    logic signed [7:0]  centered;
    logic signed [11:0] prod;

    assign wr_reg   = sel & bus.wr;
    assign trig     = wr_reg && bus.addr[1:0] == 2'd3;
    assign fetch_go = st == ST_HOLD && busy && !buf_full && !trig;
    assign take     = rom_cs & rom_ok & ~stale;
    assign rom_cs   = st == ST_FETCH;

    assign rom_byte.raw = rom_data;
    assign centered     = $signed({1'b0, buf_byte.fields.level}) - 8'(`SND_PCM_BIAS);
    assign prod         = centered * $signed({1'b0, vol});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_HOLD;
            busy     <= 1'b0;
            buf_full <= 1'b0;
            stale    <= 1'b0;
            voice    <= '0;
        end else begin
            if (cen && buf_full) begin
                buf_full <= 1'b0;
                voice    <= buf_byte.fields.eos ? '0 : prod;  // eos silences the voice
            end
            if (fetch_go) st <= ST_FETCH;
            if (rom_cs && rom_ok) begin
                st    <= ST_HOLD;  // cs drops at least one clock
                stale <= 1'b0;
            end
            if (take) begin
                buf_full <= 1'b1;
                busy     <= ~rom_byte.fields.eos;
            end
            if (trig) begin
                busy     <= 1'b1;
                buf_full <= 1'b0;
                stale    <= rom_cs & ~rom_ok;  // let the open fetch finish first
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_reg && bus.addr[1:0] == 2'd0) start[7:0]  <= bus.wdata;
        if (wr_reg && bus.addr[1:0] == 2'd1) start[15:8] <= bus.wdata;
        if (wr_reg && bus.addr[1:0] == 2'd2) vol         <= bus.wdata[3:0];
        if (fetch_go) rom_addr <= {bank, ptr};
        if (take) begin
            buf_byte <= rom_byte;
            ptr      <= ptr + 16'd1;
        end
        if (trig) ptr <= start;
    end

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom request changed before rom_ok");

endmodule

// File: logic/snd_audio_pkg.sv
/* audio sample and gain types */
package snd_audio_pkg;

    // voice output after volume scaling
    typedef logic signed [11:0] pcm_sample_t;

    // unsigned mixer gain, 8 is unity
    typedef logic [7:0] mix_gain_t;

    // pcm rom byte as the voice sees it
    typedef struct packed {
        logic       eos;    // end of sample, byte not played
        logic [6:0] level;  // offset binary
    } pcm_rom_fields_t;

    // same rom byte, raw or split into fields
    typedef union packed {
        logic [7:0]      raw;
        pcm_rom_fields_t fields;
    } pcm_rom_byte_u;

endpackage

// File: logic/snd_bus_pkg.sv
/* host bus and memory map types */
package snd_bus_pkg;

    // one host access, strobes last a single clock
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    // decoded from addr[15:12]
    typedef enum logic [3:0] {
        REG_PCMA   = 4'h9,
        REG_PCMB   = 4'hA,
        REG_BANK   = 4'hB,
        REG_LATCH  = 4'hD,
        REG_STATUS = 4'hE  // read status, write acks irq
    } map_region_e;

    // at most one bit high
    typedef struct packed {
        logic pcma;
        logic pcmb;
        logic bank;
        logic latch;
        logic status;
    } map_sel_t;

endpackage

// File: logic/snd_cen_gen.sv
/* fractional clock enable */
module snd_cen_gen #(
    parameter int N = 1,
    parameter int M = 4
) (
    input  logic clk,
    input  logic rst,
    output logic cen
);
    localparam int W = $clog2(N + M + 1);

    logic [W-1:0] acc;
    logic [W-1:0] nxt;

    assign nxt = acc + W'(N);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (nxt >= W'(M)) begin
            acc <= nxt - W'(M);  // keep the remainder, no drift
            cen <= 1'b1;
        end else begin
            acc <= nxt;
            cen <= 1'b0;
        end
    end

    // ratios of one half or less never give back to back pulses
    if (2 * N <= M) begin : g_cen_chk
        a_cen_spaced: assert property (@(posedge clk) disable iff (rst) cen |=> !cen)
            else $error("cen high on two consecutive clocks");
    end

endmodule

// File: logic/snd_ctrl_regs.sv
/* bank, irq latch and fx gain */
`include "snd_settings.svh"

module snd_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  snd_bus_pkg::bus_req_t    bus,
    input  snd_bus_pkg::map_sel_t    sel,
    input  logic                     snd_irq,
    input  logic [1:0]               fxlevel,
    input  logic [1:0]               pcm_busy,
    output logic [3:0]               banks,
    output snd_audio_pkg::mix_gain_t fx_gain,
    output logic [7:0]               status
);
    logic irq_s;      // sampled snd_irq
    logic irq_q;
    logic irq_rise;
    logic irq_pend;
    logic irq_ack;

    assign irq_rise = irq_s & ~irq_q;
    assign irq_ack  = sel.status & bus.wr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            banks    <= 4'd0;
            irq_s    <= 1'b0;
            irq_q    <= 1'b0;
            irq_pend <= 1'b0;
        end else begin
            irq_s <= snd_irq;
            irq_q <= irq_s;
            if (sel.bank && bus.wr) banks <= bus.wdata[3:0];  // pcmb bank on top
            // a new edge wins over an ack in the same cycle
            if (irq_rise) begin
                irq_pend <= 1'b1;
            end else if (irq_ack) begin
                irq_pend <= 1'b0;
            end
        end
    end

    always_comb begin
        case (fxlevel)
            2'd0:    fx_gain = `SND_FX_GAIN0;
            2'd1:    fx_gain = `SND_FX_GAIN1;
            2'd2:    fx_gain = `SND_FX_GAIN2;
            default: fx_gain = `SND_FX_GAIN3;
        endcase
    end

    assign status = {5'd0, pcm_busy[1], pcm_busy[0], irq_pend};

endmodule

// File: logic/snd_map_decode.sv
/* address decoder and read mux */
module snd_map_decode (
    input  snd_bus_pkg::bus_req_t bus,
    input  logic [7:0]            snd_latch,
    input  logic [7:0]            status,
    output snd_bus_pkg::map_sel_t sel,
    output logic [7:0]            rd_data
);
    import snd_bus_pkg::*;

    logic       acc;
    logic [3:0] region;

    assign acc    = bus.rd | bus.wr;
    assign region = bus.addr[15:12];

    always_comb begin
        sel        = '0;
        sel.pcma   = acc && region == REG_PCMA;
        sel.pcmb   = acc && region == REG_PCMB;
        sel.bank   = acc && region == REG_BANK;
        sel.latch  = acc && region == REG_LATCH;
        sel.status = acc && region == REG_STATUS;
    end

    // pcm and bank registers are write only
    always_comb begin
        if (bus.rd && sel.latch) begin
            rd_data = snd_latch;
        end else if (bus.rd && sel.status) begin
            rd_data = status;
        end else begin
            rd_data = 8'hFF;  // open bus
        end
    end

endmodule

// File: logic/snd_mixer.sv
/* fm and pcm mixer */
`include "snd_settings.svh"

module snd_mixer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic signed [15:0]         fm,
    input  snd_audio_pkg::pcm_sample_t ch_a,
    input  snd_audio_pkg::pcm_sample_t ch_b,
    input  snd_audio_pkg::mix_gain_t   fx_gain,
    output logic signed [15:0]         snd,
    output logic                       peak,
    output logic                       sample
);
    import snd_audio_pkg::*;

    localparam int        SW      = 26;
    localparam mix_gain_t GAIN_FM = `SND_GAIN_FM;

    localparam logic signed [SW-1:0] MAX_S = 32767;
    localparam logic signed [SW-1:0] MIN_S = -32768;

    logic signed [12:0]   pcm_sum;
    logic signed [SW-1:0] fm_term;
    logic signed [SW-1:0] pcm_term;
    logic signed [SW-1:0] total;
    logic signed [SW-1:0] scaled;
    logic signed [15:0]   clipped;
    logic                 sat;

    assign pcm_sum  = ch_a + ch_b;  // both voices share the fx gain
    assign fm_term  = fm * $signed({1'b0, GAIN_FM});
    assign pcm_term = pcm_sum * $signed({1'b0, fx_gain});
    assign total    = fm_term + pcm_term;
    assign scaled   = total >>> `SND_MIX_SHIFT;

    always_comb begin
        sat = 1'b1;
        if (scaled > MAX_S) begin
            clipped = 16'sh7FFF;
        end else if (scaled < MIN_S) begin
            clipped = -16'sh8000;
        end else begin
            clipped = scaled[15:0];
            sat     = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= cen;  // marks each new value
            if (cen) begin
                snd  <= clipped;
                peak <= sat;
            end
        end
    end

endmodule

// File: logic/sound_board.sv
/* arcade sound board top */
`include "snd_settings.svh"

module sound_board (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_bus_pkg::bus_req_t  bus,
    input  logic                   snd_irq,
    input  logic [7:0]             snd_latch,
    input  logic [1:0]             fxlevel,
    input  logic signed [15:0]     snd_fm,
    output logic [`SND_ROM_AW-1:0] pcma_rom_addr,
    input  logic [7:0]             pcma_rom_data,
    output logic                   pcma_rom_cs,
    input  logic                   pcma_rom_ok,
    output logic [`SND_ROM_AW-1:0] pcmb_rom_addr,
    input  logic [7:0]             pcmb_rom_data,
    output logic                   pcmb_rom_cs,
    input  logic                   pcmb_rom_ok,
    output logic [7:0]             rd_data,
    output logic signed [15:0]     snd,
    output logic                   peak,
    output logic                   sample
);
    import snd_bus_pkg::*;
    import snd_audio_pkg::*;

    logic        cen;       // sample rate enable
    map_sel_t    sel;
    logic [7:0]  status;
    logic [3:0]  banks;
    logic [1:0]  pcm_busy;
    mix_gain_t   fx_gain;
    pcm_sample_t voice_a;
    pcm_sample_t voice_b;

    snd_cen_gen #(.N(`SND_CEN_N), .M(`SND_CEN_M)) u_cen (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    snd_map_decode u_map (
        .bus       (bus),
        .snd_latch (snd_latch),
        .status    (status),
        .sel       (sel),
        .rd_data   (rd_data)
    );

    snd_ctrl_regs u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .sel      (sel),
        .snd_irq  (snd_irq),
        .fxlevel  (fxlevel),
        .pcm_busy (pcm_busy),
        .banks    (banks),
        .fx_gain  (fx_gain),
        .status   (status)
    );

    pcm_channel u_pcma (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .bus      (bus),
        .sel      (sel.pcma),
        .bank     (banks[1:0]),
        .rom_addr (pcma_rom_addr),
        .rom_data (pcma_rom_data),
        .rom_cs   (pcma_rom_cs),
        .rom_ok   (pcma_rom_ok),
        .busy     (pcm_busy[0]),
        .voice    (voice_a)
    );

    pcm_channel u_pcmb (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .bus      (bus),
        .sel      (sel.pcmb),
        .bank     (banks[3:2]),
        .rom_addr (pcmb_rom_addr),
        .rom_data (pcmb_rom_data),
        .rom_cs   (pcmb_rom_cs),
        .rom_ok   (pcmb_rom_ok),
        .busy     (pcm_busy[1]),
        .voice    (voice_b)
    );

    snd_mixer u_mixer (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .fm      (snd_fm),
        .ch_a    (voice_a),
        .ch_b    (voice_b),
        .fx_gain (fx_gain),
        .snd     (snd),
        .peak    (peak),
        .sample  (sample)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sound_board -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: tb.f
+incdir+include
logic/snd_bus_pkg.sv
logic/snd_audio_pkg.sv
logic/snd_cen_gen.sv
logic/snd_map_decode.sv
logic/snd_ctrl_regs.sv
logic/pcm_channel.sv
logic/snd_mixer.sv
logic/sound_board.sv
verification/tb_clock.sv
verification/tb_sound_board.sv

// File: verification/tb_clock.sv
/* testbench clock */
module tb_clock #(
    parameter real PERIOD = 10.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #(PERIOD / 2.0) clk = ~clk;  // 50 percent duty

endmodule

// File: verification/tb_sound_board.sv
/* sound board testbench */
`include "snd_settings.svh"

module tb_sound_board;
    timeunit 1ns;
    timeprecision 1ps;

    import snd_bus_pkg::*;

    localparam int PLAYS     = 8;
    localparam int READS     = 40;
    localparam int N_OPS     = READS + 12 + PLAYS * 30;  // bus ops plus fetched bytes
    localparam int OP_CYCLES = 16;

    logic                   clk;
    logic                   rst;
    bus_req_t               bus_req;
    logic                   snd_irq;
    logic [7:0]             snd_latch;
    logic [1:0]             fxlevel;
    logic signed [15:0]     snd_fm;
    logic [`SND_ROM_AW-1:0] rom_addr [2];
    logic [7:0]             rom_data [2];
    logic [1:0]             rom_cs;
    logic [1:0]             rom_ok;
    logic [7:0]             rd_data;
    logic signed [15:0]     snd;
    logic                   peak;
    logic                   sample;

    logic [15:0] lfsr = 16'd14627;
    string       test_name = "reset";

    // rom models
    int                     rom_wait [2];
    logic [1:0]             rom_pend = '0;
    logic [`SND_ROM_AW-1:0] eos_addr [2];

    // reference model state
    logic [15:0]        start_m [2];
    logic [15:0]        ptr_m [2];
    logic [3:0]         vol_m [2];
    logic [7:0]         buf_m [2];
    int                 voice_m [2];
    logic [3:0]         bank_m;
    logic [1:0]         busy_m;
    logic [1:0]         full_m;
    logic [1:0]         took_m;   // byte taken at the last edge
    logic               irq_s_m;
    logic               irq_q_m;
    logic               pend_m;
    int                 acc_m;
    logic               cen_m;
    logic signed [15:0] exp_snd;
    logic               exp_peak;
    logic               exp_sample;
    int                 sat_seen = 0;
    int                 clear_seen = 0;

    tb_clock u_clk (.clk(clk));

    sound_board sound_board_inst (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus_req),
        .snd_irq       (snd_irq),
        .snd_latch     (snd_latch),
        .fxlevel       (fxlevel),
        .snd_fm        (snd_fm),
        .pcma_rom_addr (rom_addr[0]),
        .pcma_rom_data (rom_data[0]),
        .pcma_rom_cs   (rom_cs[0]),
        .pcma_rom_ok   (rom_ok[0]),
        .pcmb_rom_addr (rom_addr[1]),
        .pcmb_rom_data (rom_data[1]),
        .pcmb_rom_cs   (rom_cs[1]),
        .pcmb_rom_ok   (rom_ok[1]),
        .rd_data       (rd_data),
        .snd           (snd),
        .peak          (peak),
        .sample        (sample)
    );

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] rom_byte_at(input logic [`SND_ROM_AW-1:0] addr,
                                               input logic [`SND_ROM_AW-1:0] eos);
        logic [31:0] h;
        h = 32'(addr) * 32'd40503;  // scrambles the level
        return {addr == eos, h[15:9]};
    endfunction

    // saturated mix, returns {sat, value}
    function automatic logic [16:0] mixed(input logic signed [15:0] fm, input int va,
                                          input int vb, input logic [1:0] fx);
        int gain;
        int total;
        int scaled;
        case (fx)
            2'd0:    gain = `SND_FX_GAIN0;
            2'd1:    gain = `SND_FX_GAIN1;
            2'd2:    gain = `SND_FX_GAIN2;
            default: gain = `SND_FX_GAIN3;
        endcase
        total  = int'(fm) * `SND_GAIN_FM + (va + vb) * gain;
        scaled = total >>> `SND_MIX_SHIFT;
        if (scaled > 32767) return {1'b1, 16'h7FFF};
        if (scaled < -32768) return {1'b1, 16'h8000};
        return {1'b0, scaled[15:0]};
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic bus_op(input logic [15:0] addr, input logic [7:0] wdata, input logic rd,
                          input logic wr, output logic [7:0] data);
        @(posedge clk);
        #1;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.rd    = rd;
        bus_req.wr    = wr;
        @(negedge clk);
        data = rd_data;
        @(posedge clk);
        #1;
        bus_req = '0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] wdata);
        logic [7:0] unused;
        bus_op(addr, wdata, 1'b0, 1'b1, unused);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // ok after 0 to 3 cycles, dropped once cs falls
    always @(posedge clk) begin
        #1;
        for (int c = 0; c < 2; c++) begin
            if (!rom_cs[c]) begin
                rom_ok[c]   = 1'b0;
                rom_pend[c] = 1'b0;
            end else if (!rom_pend[c] && !rom_ok[c]) begin
                rom_pend[c] = 1'b1;
                rom_wait[c] = int'(rand_bits(2));
            end
            if (rom_pend[c]) begin
                if (rom_wait[c] == 0) begin
                    rom_ok[c]   = 1'b1;
                    rom_pend[c] = 1'b0;
                    rom_data[c] = rom_byte_at(rom_addr[c], eos_addr[c]);
                end else begin
                    rom_wait[c]--;
                end
            end
        end
    end

    // check what the last edge did, then predict the next edge
    always @(negedge clk) begin : monitor
        logic [16:0] mix;
        logic [3:0]  rgn;
        logic [7:0]  exp_rd;
        rgn = bus_req.addr[15:12];
        if (rst) begin
            busy_m     = '0;
            full_m     = '0;
            took_m     = '0;
            bank_m     = '0;
            irq_s_m    = 1'b0;
            irq_q_m    = 1'b0;
            pend_m     = 1'b0;
            acc_m      = 0;
            cen_m      = 1'b0;
            exp_snd    = '0;
            exp_peak   = 1'b0;
            exp_sample = 1'b0;
            voice_m    = '{0, 0};
        end else begin
            check("sample", exp_sample, sample);
            check("snd", exp_snd, snd);
            check("peak", exp_peak, peak);
            if (bus_req.rd && rgn == REG_LATCH) exp_rd = snd_latch;
            else if (bus_req.rd && rgn == REG_STATUS) exp_rd = {5'd0, busy_m, pend_m};
            else exp_rd = 8'hFF;
            check("read data", exp_rd, rd_data);
            for (int c = 0; c < 2; c++) begin
                check("rom cs drop after ok", 0, rom_cs[c] & took_m[c]);
                if (rom_cs[c]) begin
                    check("rom address", {c ? bank_m[3:2] : bank_m[1:0], ptr_m[c]}, rom_addr[c]);
                    check("fetch past end", 1, busy_m[c]);
                end
            end

            exp_sample = cen_m;
            if (cen_m) begin
                mix      = mixed(snd_fm, voice_m[0], voice_m[1], fxlevel);
                exp_peak = mix[16];
                exp_snd  = mix[15:0];
                if (mix[16]) sat_seen++;
                else clear_seen++;
                for (int c = 0; c < 2; c++) begin
                    if (full_m[c]) begin
                        voice_m[c] = buf_m[c][7] ? 0 :
                                     (int'(buf_m[c][6:0]) - `SND_PCM_BIAS) * int'(vol_m[c]);
                        full_m[c]  = 1'b0;
                    end
                end
            end
            if (acc_m + `SND_CEN_N >= `SND_CEN_M) begin
                acc_m = acc_m + `SND_CEN_N - `SND_CEN_M;
                cen_m = 1'b1;
            end else begin
                acc_m = acc_m + `SND_CEN_N;
                cen_m = 1'b0;
            end

            for (int c = 0; c < 2; c++) begin
                took_m[c] = rom_cs[c] & rom_ok[c];
                if (rom_cs[c] && rom_ok[c]) begin  // byte taken at this edge
                    buf_m[c]  = rom_data[c];
                    full_m[c] = 1'b1;
                    busy_m[c] = !rom_data[c][7];
                    ptr_m[c]++;
                end
                if (bus_req.wr && rgn == (c ? REG_PCMB : REG_PCMA)) begin
                    case (bus_req.addr[1:0])
                        2'd0: start_m[c][7:0]  = bus_req.wdata;
                        2'd1: start_m[c][15:8] = bus_req.wdata;
                        2'd2: vol_m[c]         = bus_req.wdata[3:0];
                        default: begin
                            ptr_m[c]  = start_m[c];
                            busy_m[c] = 1'b1;
                            full_m[c] = 1'b0;
                        end
                    endcase
                end
            end
            if (bus_req.wr && rgn == REG_BANK) bank_m = bus_req.wdata[3:0];
            if (irq_s_m && !irq_q_m) pend_m = 1'b1;
            else if (bus_req.wr && rgn == REG_STATUS) pend_m = 1'b0;
            irq_q_m = irq_s_m;
            irq_s_m = snd_irq;
        end
    end

    initial begin : stimulus
        logic [7:0]  data;
        logic [3:0]  bank;
        logic [15:0] start;
        logic [15:0] base;
        logic [15:0] addr;
        int          len;
        bus_req     = '0;
        snd_irq     = 1'b0;
        snd_latch   = 8'h00;
        fxlevel     = 2'd0;
        snd_fm      = '0;
        rom_ok      = '0;
        rom_data    = '{8'h00, 8'h00};
        eos_addr    = '{'1, '1};
        rst         = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        test_name = "random reads";
        repeat (READS) begin
            snd_latch = 8'(rand_bits(8));
            addr      = 16'(rand_bits(16));
            if (rand_bits(1)) addr[15:12] = REG_LATCH;  // half the reads hit the latch
            bus_op(addr, 8'h00, 1'b1, 1'b0, data);
        end

        test_name = "irq latch";
        snd_irq = 1'b1;
        idle(3);
        bus_op(16'hE000, 8'h00, 1'b1, 1'b0, data);
        check("set on rising edge", 1, data[0]);
        bus_write(16'hE000, 8'h00);
        bus_op(16'hE000, 8'h00, 1'b1, 1'b0, data);
        check("cleared by ack", 0, data[0]);
        idle(4);
        bus_op(16'hE000, 8'h00, 1'b1, 1'b0, data);
        check("held level", 0, data[0]);  // no new edge
        snd_irq = 1'b0;
        idle(2);
        snd_irq = 1'b1;
        idle(3);
        bus_op(16'hE000, 8'h00, 1'b1, 1'b0, data);
        check("second edge", 1, data[0]);
        bus_write(16'hE000, 8'h00);
        snd_irq = 1'b0;

        test_name = "playback and mixing";
        repeat (PLAYS) begin
            bank = 4'(rand_bits(4));
            bus_write(16'hB000, {4'd0, bank});
            fxlevel = 2'(rand_bits(2));
            case (rand_bits(2))
                0:       snd_fm = 16'sh7FFF;  // forces clipping
                1:       snd_fm = 16'sh8000;
                default: snd_fm = $signed(16'(rand_bits(16))) >>> 2;
            endcase
            for (int c = 0; c < 2; c++) begin
                start       = 16'(rand_bits(16));
                len         = 2 + int'(rand_bits(3));
                base        = c ? 16'hA000 : 16'h9000;
                eos_addr[c] = {c ? bank[3:2] : bank[1:0], 16'(start + 16'(len))};
                bus_write(base, start[7:0]);
                bus_write(base | 16'd1, start[15:8]);
                bus_write(base | 16'd2, {4'd0, 4'(rand_bits(4))});
            end
            bus_write(16'h9003, 8'h00);
            bus_write(16'hA003, 8'h00);
            do begin
                bus_op(16'hE000, 8'h00, 1'b1, 1'b0, data);
            end while (data[2:1] != 2'b00);
            idle(2 * `SND_CEN_M);  // eos byte reaches the voice
        end

        test_name = "peak coverage";
        check("saturated samples seen", 1, sat_seen > 0);
        check("clean samples seen", 1, clear_seen > 0);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        #((N_OPS * OP_CYCLES + 20) * 10);
        $display("watchdog: the run did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule
